/* src.f */
+incdir+common
common/noc_pkg.sv
common/ssa_pkg.sv
ssa/ssa_cfg_regs.sv
ssa/ssa_per_vc.sv
ssa/ss_allocator.sv
tests/ss_allocator_properties.sv
tests/ss_allocator_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module ss_allocator_tb -o ss_allocator_sim &&
    ./obj_dir/ss_allocator_sim |
    awk '{ print } /^TESTBENCH PASSED$/ { ok = 1 } END { exit !ok }' &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

/* tests/ss_allocator_tb.sv */
`timescale 1ns/1ps
`include "ssa_consts.svh"

module ss_allocator_tb;

    localparam int P           = `SSA_P;
    localparam int V           = `SSA_V;
    localparam int ACK_TIMEOUT = 16;    // cycles
    localparam int RAND_CYCLES = 400;

    logic                                     clk;
    logic                                     rst_n;
    noc_pkg::flit_t       [P-1:0]             flit;
    logic                 [P-1:0]             flit_wr;
    logic                 [P-1:0]             sw_granted;
    logic                 [P-1:0]             ovc_granted;
    noc_pkg::ivc_status_t [P-1:0][V-1:0]      ivc_stat;
    noc_pkg::ovc_status_t [P-1:0][V-1:0]      ovc_stat;
    ssa_pkg::cfg_req_t                        cfg;
    ssa_pkg::ssa_ctrl_t   [P-1:0]             ctrl;
    logic                                     cfg_ack;
    logic                 [P-1:0]             cfg_rdata;
    logic                 [15:0]              lfsr;

    ss_allocator dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .flit_i        (flit),
        .flit_wr_i     (flit_wr),
        .sw_granted_i  (sw_granted),
        .ovc_granted_i (ovc_granted),
        .ivc_stat_i    (ivc_stat),
        .ovc_stat_i    (ovc_stat),
        .cfg_i         (cfg),
        .ctrl_o        (ctrl),
        .cfg_ack_o     (cfg_ack),
        .cfg_rdata_o   (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois taps 16 14 13 11
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    function automatic logic [P-1:0] port_bit(input int p);
        return P'(1) << p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // any failed property ends the run at once
    always @(negedge clk) begin
        if (dut.u_props.fail_count != 0) begin
            abort_run($sformatf("%0d property checks failed", dut.u_props.fail_count));
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        flit_wr     = '0;
        sw_granted  = '0;
        ovc_granted = '0;
        for (int p = 0; p < P; p++) begin
            flit[p] = '0;
            for (int v = 0; v < V; v++) begin
                ivc_stat[p][v]           = '0;
                ovc_stat[p][v].available = 1'b1;
                ovc_stat[p][v].full      = 1'b0;
            end
        end
    endtask

    task automatic put_flit(input int p, input int v, input logic hdr, input logic tail,
                            input int dest);
        flit[p].hdr       = hdr;
        flit[p].tail      = tail;
        flit[p].vc        = V'(1) << v;
        flit[p].dest_port = hdr ? port_bit(dest) : '0;   // body flits carry no route
        flit[p].payload   = `SSA_PAYLOAD_W'(rand_bits(`SSA_PAYLOAD_W));
        flit_wr[p]        = 1'b1;
    endtask

    // one active cycle, then one idle cycle so the flit-write strobe shows
    task automatic run_cycle();
        step();
        idle_inputs();
        step();
    endtask

    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        step();
        while (cfg_ack !== level && n < ACK_TIMEOUT) begin
            step();
            n++;
        end
        if (cfg_ack !== level) begin
            abort_run($sformatf("timeout: cfg ack never went %0d during %s", level, what));
        end
    endtask

    task automatic cfg_transfer(input ssa_pkg::cfg_op_e op, input logic [P-1:0] wdata,
                                input string what, output logic [P-1:0] rdata);
        cfg.req   = 1'b1;
        cfg.op    = op;
        cfg.wdata = wdata;
        wait_ack(1'b1, what);
        rdata   = cfg_rdata;
        cfg.req = 1'b0;
        wait_ack(1'b0, what);
    endtask

    task automatic check_value(input string name, input logic [P-1:0] expected,
                               input logic [P-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic random_inputs();
        int d;
        for (int p = 0; p < P; p++) begin
            flit_wr[p]        = rand_bit();
            sw_granted[p]     = (rand_bits(2) == 0);   // mostly free
            ovc_granted[p]    = (rand_bits(2) == 0);
            flit[p].hdr       = rand_bit();
            flit[p].tail      = rand_bit();
            flit[p].vc        = V'(1) << rand_bit();
            d                 = int'(rand_bits(3)) % P;
            flit[p].dest_port = flit[p].hdr ? port_bit(d) : '0;
            flit[p].payload   = `SSA_PAYLOAD_W'(rand_bits(`SSA_PAYLOAD_W));
            for (int v = 0; v < V; v++) begin
                ivc_stat[p][v].ivc_req         = (rand_bits(2) == 0);
                ivc_stat[p][v].ovc_is_assigned = rand_bit();
                ivc_stat[p][v].assigned_ovc    = V'(1) << rand_bit();
                d                              = int'(rand_bits(3)) % P;
                ivc_stat[p][v].dest_port       = port_bit(d);
                ovc_stat[p][v].available       = (rand_bits(2) != 0);
                ovc_stat[p][v].full            = (rand_bits(2) == 0);
            end
        end
    endtask

    initial begin
        logic [P-1:0] rd;
        logic [P-1:0] no_north;
        lfsr = 16'd7944;
        cfg  = '0;
        idle_inputs();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        step();

        // straight headers on every pair and both VCs
        for (int v = 0; v < V; v++) begin
            put_flit(`SSA_PORT_WEST, v, 1'b1, 1'b0, `SSA_PORT_EAST);
            run_cycle();
            put_flit(`SSA_PORT_SOUTH, v, 1'b1, 1'b0, `SSA_PORT_NORTH);
            run_cycle();
        end

        // each blocking condition on its own
        for (int k = 0; k < 4; k++) begin
            case (k)
                0:       sw_granted[`SSA_PORT_WEST] = 1'b1;
                1:       ovc_granted[`SSA_PORT_EAST] = 1'b1;
                2:       ivc_stat[`SSA_PORT_WEST][0].ivc_req = 1'b1;
                default: ovc_stat[`SSA_PORT_EAST][0].available = 1'b0;
            endcase
            put_flit(`SSA_PORT_WEST, 0, 1'b1, 1'b0, `SSA_PORT_EAST);
            run_cycle();
        end

        // turning header, then traffic on the local port
        put_flit(`SSA_PORT_WEST, 0, 1'b1, 1'b0, `SSA_PORT_NORTH);
        run_cycle();
        put_flit(`SSA_PORT_LOCAL, 1, 1'b1, 1'b1, `SSA_PORT_EAST);
        run_cycle();

        // body and tail on an assigned ovc, with and without room
        for (int full = 0; full < 2; full++) begin
            for (int tail = 0; tail < 2; tail++) begin
                ivc_stat[`SSA_PORT_SOUTH][1].ovc_is_assigned = 1'b1;
                ivc_stat[`SSA_PORT_SOUTH][1].assigned_ovc    = 2'b10;
                ivc_stat[`SSA_PORT_SOUTH][1].dest_port       = port_bit(`SSA_PORT_NORTH);
                ovc_stat[`SSA_PORT_NORTH][1].full            = 1'(full);
                put_flit(`SSA_PORT_SOUTH, 1, 1'b0, 1'(tail), 0);
                run_cycle();
            end
        end

        // single-flit packet
        put_flit(`SSA_PORT_EAST, 1, 1'b1, 1'b1, `SSA_PORT_WEST);
        run_cycle();

        // clear the north enable and read it back
        no_north = `SSA_EN_RESET & ~port_bit(`SSA_PORT_NORTH);
        cfg_transfer(ssa_pkg::CFG_WRITE_EN, no_north, "cfg write", rd);
        check_value("cfg write echo", no_north, rd);
        cfg_transfer(ssa_pkg::CFG_READ_EN, '0, "cfg read", rd);
        check_value("cfg read back", no_north, rd);
        put_flit(`SSA_PORT_NORTH, 0, 1'b1, 1'b0, `SSA_PORT_SOUTH);
        run_cycle();
        put_flit(`SSA_PORT_NORTH, 1, 1'b1, 1'b1, `SSA_PORT_SOUTH);
        run_cycle();

        cfg_transfer(ssa_pkg::CFG_WRITE_EN, `SSA_EN_RESET, "cfg restore", rd);
        check_value("cfg restore echo", `SSA_EN_RESET, rd);

        // random traffic and status
        repeat (RAND_CYCLES) begin
            random_inputs();
            step();
        end
        idle_inputs();
        step();
        step();

        if (dut.u_props.fail_count != 0) begin
            abort_run($sformatf("%0d property checks failed", dut.u_props.fail_count));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* tests/ss_allocator_properties.sv */
`timescale 1ns/1ps
`include "ssa_consts.svh"

module ss_allocator_properties (
    input logic                                       clk,
    input logic                                       rst_n_i,
    input noc_pkg::flit_t       [`SSA_P-1:0]              flit_i,
    input logic                 [`SSA_P-1:0]              flit_wr_i,
    input logic                 [`SSA_P-1:0]              sw_granted_i,
    input logic                 [`SSA_P-1:0]              ovc_granted_i,
    input noc_pkg::ivc_status_t [`SSA_P-1:0][`SSA_V-1:0] ivc_stat_i,
    input noc_pkg::ovc_status_t [`SSA_P-1:0][`SSA_V-1:0] ovc_stat_i,
    input ssa_pkg::cfg_req_t                              cfg_i,
    input ssa_pkg::ssa_ctrl_t   [`SSA_P-1:0]              ctrl_i,
    input logic                                           cfg_ack_i,
    input logic                 [`SSA_P-1:0]              cfg_rdata_i
);

    localparam int P = `SSA_P;
    localparam int V = `SSA_V;

    int fail_count = 0;   // read by the testbench

    logic [P-1:0][V-1:0]        e_sw, e_ovc, e_rst, e_single;   // by input port
    logic [P-1:0][V-1:0]        e_alloc, e_rel, e_cred;         // by output port
    logic [P-1:0][V-1:0][V-1:0] e_gnt;
    logic [P-1:0]               e_to_port;
    logic [P-1:0]               m_mask, m_rdata, m_flit_wr;
    logic                       m_busy;

    // expected per-VC decisions
    always_comb begin
        int                   s;
        noc_pkg::flit_t       f;
        noc_pkg::ivc_status_t st;
        noc_pkg::ovc_status_t os;
        logic                 ready;
        logic                 ok;
        logic                 single;
        s = 0;
        f = '0;
        st = '0;
        os = '0;
        ready = 1'b0;
        ok = 1'b0;
        single = 1'b0;
        e_sw = '0;
        e_ovc = '0;
        e_rst = '0;
        e_single = '0;
        e_alloc = '0;
        e_rel = '0;
        e_cred = '0;
        e_gnt = '0;
        e_to_port = '0;
        for (int p = 0; p < P; p++) begin
            if (p != `SSA_PORT_LOCAL) begin
                s = ((p + 1) % 4) + 1;   // east 1 <-> west 3, north 2 <-> south 4
                f = flit_i[p];
                single = f.hdr && f.tail;
                for (int v = 0; v < V; v++) begin
                    st = ivc_stat_i[p][v];
                    os = ovc_stat_i[s][v];
                    if (st.ovc_is_assigned) begin
                        ready = st.dest_port[s] && st.assigned_ovc[v] && !os.full;
                    end else begin
                        ready = os.available;
                    end
                    ok = m_mask[p] && !st.ivc_req && !sw_granted_i[p] && !ovc_granted_i[s]
                       && ready && flit_wr_i[p] && f.vc[v];
                    e_single[p][v] = single;
                    e_sw[p][v]     = ok && !(f.hdr && !f.dest_port[s]);
                    e_ovc[p][v]    = ok && f.hdr && f.dest_port[s];
                    e_rst[p][v]    = single ? e_sw[p][v] : (ok && f.tail);
                    e_gnt[p][v]    = e_ovc[p][v] ? (V'(1) << v) : '0;
                    e_cred[s][v]   = e_sw[p][v];
                    e_alloc[s][v]  = e_ovc[p][v] && !single;
                    e_rel[s][v]    = e_rst[p][v] && !single;
                    if (e_sw[p][v]) begin
                        e_to_port[s] = 1'b1;
                    end
                end
            end
        end
    end

    // config handshake and flit-write model
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            m_busy    <= 1'b0;
            m_mask    <= `SSA_EN_RESET;
            m_rdata   <= '0;
            m_flit_wr <= '0;
        end else begin
            m_flit_wr <= e_to_port;   // one cycle after the switch grant
            if (!m_busy && cfg_i.req) begin
                m_busy <= 1'b1;
                if (cfg_i.op == ssa_pkg::CFG_READ_EN) begin
                    m_rdata <= m_mask;
                end else begin
                    m_mask  <= cfg_i.wdata;
                    m_rdata <= cfg_i.wdata;
                end
            end else if (m_busy && !cfg_i.req) begin
                m_busy <= 1'b0;
            end
        end
    end

    for (genvar p = 0; p < P; p++) begin : g_chk
        a_ivc_grants: assert property (@(posedge clk) disable iff (!rst_n_i)
            ctrl_i[p].ivc_sw_grant == e_sw[p] && ctrl_i[p].ivc_ovc_grant == e_ovc[p]
            && ctrl_i[p].granted_ovc == e_gnt[p])
            else begin
                fail_count++;
                $error("port %0d: input VC grants differ from the reference model", p);
            end

        a_ivc_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
            ctrl_i[p].ivc_reset == e_rst[p] && ctrl_i[p].ivc_single_flit == e_single[p])
            else begin
                fail_count++;
                $error("port %0d: ivc_reset or single flag differs from the model", p);
            end

        a_ovc_side: assert property (@(posedge clk) disable iff (!rst_n_i)
            ctrl_i[p].ovc_allocated == e_alloc[p] && ctrl_i[p].ovc_released == e_rel[p]
            && ctrl_i[p].credit_decreased == e_cred[p])
            else begin
                fail_count++;
                $error("port %0d: output VC alloc, release or credit is wrong", p);
            end

        a_flit_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
            ctrl_i[p].ssa_flit_wr == m_flit_wr[p])
            else begin
                fail_count++;
                $error("port %0d: ssa_flit_wr not exactly one cycle after grant", p);
            end
    end

    a_local_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctrl_i[`SSA_PORT_LOCAL].ivc_sw_grant == '0 && ctrl_i[`SSA_PORT_LOCAL].ivc_ovc_grant == '0
        && ctrl_i[`SSA_PORT_LOCAL].ivc_reset == '0)
        else begin
            fail_count++;
            $error("local port issued a straight grant");
        end

    a_cfg_ack: assert property (@(posedge clk) disable iff (!rst_n_i) cfg_ack_i == m_busy)
        else begin
            fail_count++;
            $error("cfg ack does not follow the four-phase handshake");
        end

    a_cfg_rdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        cfg_ack_i |-> cfg_rdata_i == m_rdata)
        else begin
            fail_count++;
            $error("cfg read data wrong while ack is high");
        end

endmodule

bind ss_allocator ss_allocator_properties u_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flit_i        (flit_i),
    .flit_wr_i     (flit_wr_i),
    .sw_granted_i  (sw_granted_i),
    .ovc_granted_i (ovc_granted_i),
    .ivc_stat_i    (ivc_stat_i),
    .ovc_stat_i    (ovc_stat_i),
    .cfg_i         (cfg_i),
    .ctrl_i        (ctrl_o),
    .cfg_ack_i     (cfg_ack_o),
    .cfg_rdata_i   (cfg_rdata_o)
);

/* ssa/ss_allocator.sv */
`timescale 1ns/1ps
`include "ssa_consts.svh"

module ss_allocator (
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  noc_pkg::flit_t      [`SSA_P-1:0]              flit_i,
    input  logic                [`SSA_P-1:0]              flit_wr_i,
    input  logic                [`SSA_P-1:0]              sw_granted_i,
    input  logic                [`SSA_P-1:0]              ovc_granted_i,
    input  noc_pkg::ivc_status_t [`SSA_P-1:0][`SSA_V-1:0] ivc_stat_i,
    input  noc_pkg::ovc_status_t [`SSA_P-1:0][`SSA_V-1:0] ovc_stat_i,
    input  ssa_pkg::cfg_req_t                             cfg_i,
    output ssa_pkg::ssa_ctrl_t  [`SSA_P-1:0]              ctrl_o,
    output logic                                          cfg_ack_o,
    output logic                [`SSA_P-1:0]              cfg_rdata_o
);

    localparam int P = `SSA_P;
    localparam int V = `SSA_V;

    // east/west and north/south face each other, local has no partner
    function automatic int straight_port(int p);
        case (p)
            int'(noc_pkg::EAST):  return int'(noc_pkg::WEST);
            int'(noc_pkg::WEST):  return int'(noc_pkg::EAST);
            int'(noc_pkg::NORTH): return int'(noc_pkg::SOUTH);
            int'(noc_pkg::SOUTH): return int'(noc_pkg::NORTH);
            default:              return int'(noc_pkg::LOCAL);
        endcase
    endfunction

    logic [P-1:0]          en_mask;
    logic [P-1:0][V-1:0]   sw_grant, ovc_grant, ivc_reset, single;   // by input port
    logic [P-1:0][V-1:0]   ovc_alloc, ovc_release, credit_dec;       // by output port
    logic [P-1:0]          sw_to_port;    // some straight input switched into this port
    logic [P-1:0]          ssa_flit_wr_q;

    ssa_cfg_regs u_cfg_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .en_mask_o   (en_mask)
    );

    for (genvar p = 0; p < P; p++) begin : g_port
        localparam int SS = straight_port(p);

        if (SS == int'(noc_pkg::LOCAL)) begin : g_local
            assign sw_grant[p]    = '0;
            assign ovc_grant[p]   = '0;
            assign ivc_reset[p]   = '0;
            assign single[p]      = '0;
            assign ovc_alloc[p]   = '0;   // local is nobody's straight port
            assign ovc_release[p] = '0;
            assign credit_dec[p]  = '0;
            assign sw_to_port[p]  = 1'b0;
        end else begin : g_ssa
            for (genvar v = 0; v < V; v++) begin : g_vc
                ssa_per_vc #(
                    .IN_PORT (p),
                    .SS_PORT (SS),
                    .VC      (v)
                ) u_per_vc (
                    .flit_i           (flit_i[p]),
                    .flit_wr_i        (flit_wr_i[p]),
                    .sw_granted_i     (sw_granted_i[p]),
                    .ss_ovc_granted_i (ovc_granted_i[SS]),
                    .ivc_stat_i       (ivc_stat_i[p][v]),
                    .ss_ovc_stat_i    (ovc_stat_i[SS][v]),
                    .en_i             (en_mask[p]),
                    .sw_grant_o       (sw_grant[p][v]),
                    .ovc_grant_o      (ovc_grant[p][v]),
                    .ivc_reset_o      (ivc_reset[p][v]),
                    .credit_dec_o     (credit_dec[SS][v]),
                    .ovc_alloc_o      (ovc_alloc[SS][v]),
                    .ovc_release_o    (ovc_release[SS][v]),
                    .single_flit_o    (single[p][v])
                );
            end
            assign sw_to_port[SS] = |sw_grant[p];
        end

        assign ctrl_o[p].ovc_allocated    = ovc_alloc[p];
        assign ctrl_o[p].ovc_released     = ovc_release[p];
        assign ctrl_o[p].credit_decreased = credit_dec[p];
        assign ctrl_o[p].ivc_sw_grant     = sw_grant[p];
        assign ctrl_o[p].ivc_ovc_grant    = ovc_grant[p];
        assign ctrl_o[p].ivc_reset        = ivc_reset[p];
        assign ctrl_o[p].ivc_single_flit  = single[p];
        assign ctrl_o[p].ssa_flit_wr      = ssa_flit_wr_q[p];

        // straight bypass keeps the vc number
        for (genvar v = 0; v < V; v++) begin : g_gnt
            assign ctrl_o[p].granted_ovc[v] = {V{ovc_grant[p][v]}} & (V'(1) << v);
        end
    end

    // flit reaches the straight output one cycle after its switch grant
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ssa_flit_wr_q <= '0;
        end else begin
            ssa_flit_wr_q <= sw_to_port;
        end
    end

endmodule

/* ssa/ssa_per_vc.sv */
`timescale 1ns/1ps
`include "ssa_consts.svh"

module ssa_per_vc #(
    parameter int IN_PORT = `SSA_PORT_WEST,
    parameter int SS_PORT = `SSA_PORT_EAST,
    parameter int VC      = 0
) (
    input  noc_pkg::flit_t       flit_i,
    input  logic                 flit_wr_i,
    input  logic                 sw_granted_i,       // some ivc of this input won the switch
    input  logic                 ss_ovc_granted_i,   // straight output already taken
    input  noc_pkg::ivc_status_t ivc_stat_i,
    input  noc_pkg::ovc_status_t ss_ovc_stat_i,      // output VC VC at SS_PORT
    input  logic                 en_i,
    output logic                 sw_grant_o,
    output logic                 ovc_grant_o,
    output logic                 ivc_reset_o,
    output logic                 credit_dec_o,
    output logic                 ovc_alloc_o,
    output logic                 ovc_release_o,
    output logic                 single_flit_o
);

    // a pair that is not a real straight path never bypasses
    localparam bit PAIR_OK = (SS_PORT != IN_PORT) &&
                             (SS_PORT != `SSA_PORT_LOCAL) &&
                             (IN_PORT != `SSA_PORT_LOCAL);

    logic vc_wr;        // flit written into this VC
    logic single;
    logic hdr_to_ss;    // incoming header heads straight on
    logic buf_to_ss;    // buffered packet already heads straight on
    logic ss_ready;
    logic permit;
    logic go;
    logic credit_pre;
    logic release_pre;

    assign vc_wr     = flit_wr_i & flit_i.vc[VC];
    assign single    = flit_i.hdr & flit_i.tail;
    assign hdr_to_ss = flit_i.dest_port[SS_PORT];
    assign buf_to_ss = ivc_stat_i.dest_port[SS_PORT];

    // an assigned ovc must be our own straight ovc with room
    always_comb begin
        if (ivc_stat_i.ovc_is_assigned) begin
            ss_ready = buf_to_ss & ivc_stat_i.assigned_ovc[VC] & ~ss_ovc_stat_i.full;
        end else begin
            ss_ready = ss_ovc_stat_i.available;
        end
    end

    assign permit = PAIR_OK & en_i & ~ivc_stat_i.ivc_req & ~sw_granted_i
                  & ~ss_ovc_granted_i & ss_ready;
    assign go     = permit & vc_wr;

    // turning headers stay with the normal allocator
    assign credit_pre  = ~(flit_i.hdr & ~hdr_to_ss);
    assign release_pre = single ? credit_pre : flit_i.tail;

    assign sw_grant_o    = go & credit_pre;
    assign credit_dec_o  = go & credit_pre;   // one flit into the straight ovc
    assign ovc_grant_o   = go & flit_i.hdr & hdr_to_ss;
    assign ivc_reset_o   = go & release_pre;

    // single-flit packets never hold the ovc
    assign ovc_alloc_o   = ovc_grant_o & ~single;
    assign ovc_release_o = ivc_reset_o & ~single;
    assign single_flit_o = single;

endmodule

/* ssa/ssa_cfg_regs.sv */
`timescale 1ns/1ps
`include "ssa_consts.svh"

module ssa_cfg_regs (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ssa_pkg::cfg_req_t   cfg_i,
    output logic                cfg_ack_o,
    output logic [`SSA_P-1:0]   cfg_rdata_o,
    output logic [`SSA_P-1:0]   en_mask_o
);

    typedef enum logic {
        CFG_IDLE,
        CFG_ACK
    } cfg_state_e;

    cfg_state_e state_q;
    logic       accept;

    // a request is taken only from idle, so each req pulse acts once
    assign accept    = cfg_i.req && (state_q == CFG_IDLE);
    assign cfg_ack_o = (state_q == CFG_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= CFG_IDLE;
            en_mask_o <= `SSA_EN_RESET;
        end else begin
            case (state_q)
                CFG_IDLE: if (cfg_i.req) state_q <= CFG_ACK;
                CFG_ACK:  if (!cfg_i.req) state_q <= CFG_IDLE;   // wait for master to drop
                default:  state_q <= CFG_IDLE;
            endcase
            if (accept && cfg_i.op == ssa_pkg::CFG_WRITE_EN) begin
                en_mask_o <= cfg_i.wdata;
            end
        end
    end

    // read data, valid while ack is high
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cfg_i.op)
                ssa_pkg::CFG_WRITE_EN: cfg_rdata_o <= cfg_i.wdata;   // echo written mask
                ssa_pkg::CFG_READ_EN:  cfg_rdata_o <= en_mask_o;
                default:               cfg_rdata_o <= en_mask_o;
            endcase
        end
    end

endmodule

/* common/ssa_pkg.sv */
package ssa_pkg;

`include "ssa_consts.svh"

    // per port control towards the router, indexed by VC of that port
    typedef struct packed {
        logic [`SSA_V-1:0]             ovc_allocated;     // output VC side
        logic [`SSA_V-1:0]             ovc_released;
        logic [`SSA_V-1:0]             credit_decreased;
        logic [`SSA_V-1:0]             ivc_sw_grant;      // input VC side
        logic [`SSA_V-1:0]             ivc_ovc_grant;
        logic [`SSA_V-1:0]             ivc_reset;
        logic [`SSA_V-1:0]             ivc_single_flit;
        logic [`SSA_V-1:0][`SSA_V-1:0] granted_ovc;       // one-hot ovc per input VC
        logic                          ssa_flit_wr;       // registered, one cycle late
    } ssa_ctrl_t;

    typedef enum logic {
        CFG_WRITE_EN = 1'b0,
        CFG_READ_EN  = 1'b1
    } cfg_op_e;

    // held stable by the master while req is high
    typedef struct packed {
        logic              req;
        cfg_op_e           op;
        logic [`SSA_P-1:0] wdata;
    } cfg_req_t;

endpackage

/* common/noc_pkg.sv */
package noc_pkg;

`include "ssa_consts.svh"

    typedef enum logic [2:0] {
        LOCAL = `SSA_PORT_LOCAL,
        EAST  = `SSA_PORT_EAST,
        NORTH = `SSA_PORT_NORTH,
        WEST  = `SSA_PORT_WEST,
        SOUTH = `SSA_PORT_SOUTH
    } port_e;

    // flit as seen on a router input
    typedef struct packed {
        logic                      hdr;        // first flit of a packet
        logic                      tail;       // last flit of a packet
        logic [`SSA_V-1:0]         vc;         // one-hot
        logic [`SSA_P-1:0]         dest_port;  // one-hot, header only
        logic [`SSA_PAYLOAD_W-1:0] payload;
    } flit_t;

    // state of one input VC, driven by the VC allocator side
    typedef struct packed {
        logic              ivc_req;          // already competing in normal allocation
        logic              ovc_is_assigned;
        logic [`SSA_V-1:0] assigned_ovc;     // one-hot
        logic [`SSA_P-1:0] dest_port;        // of the packet already buffered
    } ivc_status_t;

    // state of one output VC
    typedef struct packed {
        logic available;
        logic full;
    } ovc_status_t;

endpackage

/* common/ssa_consts.svh */
`ifndef SSA_CONSTS_SVH
`define SSA_CONSTS_SVH

// router geometry
`define SSA_P          5
`define SSA_V          2
`define SSA_PAYLOAD_W  16

// port numbering of a 2D mesh router
`define SSA_PORT_LOCAL 0
`define SSA_PORT_EAST  1
`define SSA_PORT_NORTH 2
`define SSA_PORT_WEST  3
`define SSA_PORT_SOUTH 4

// straight allocation enabled on every input after reset
`define SSA_EN_RESET   5'b11111

`endif
